// ==== filelist.f ====
verilog/ccu_pkg.sv
verilog/ccu_arb.sv
verilog/ccu_biu.sv
verilog/ccu_top.sv
testbench/ccu_mem_model.sv
testbench/ccu_props.sv
testbench/ccu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compiles the CCU testbench with Verilator, runs it, and scans the log.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module ccu_tb \
    -f filelist.f --Mdir obj_dir -o Vccu_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vccu_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "Test passed" sim.log && ! grep -q "Test failed" sim.log \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }

// ==== testbench/ccu_tb.sv ====
/*
 * Directed testbench for the core communications unit.
 * Three requestors drive ccu_top_inst, a word memory model answers on the
 * bus, and every returned line is compared with a reference word array.
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_tb import ccu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 400;

    logic                            clk = 1'b0;
    logic                            i_reset;
    logic [ARB_DEPTH-1:0]            i_ccu_valid;
    logic [ARB_DEPTH-1:0]            i_ccu_we;
    logic [ARB_DEPTH*LEN_WIDTH-1:0]  i_ccu_len;
    logic [ARB_DEPTH*ADDR_WIDTH-1:0] i_ccu_addr;
    logic [ARB_DEPTH*LINE_WIDTH-1:0] i_ccu_data;
    logic [ARB_DEPTH-1:0]            o_ccu_done;
    logic [ARB_DEPTH-1:0]            o_ccu_grant;
    logic [LINE_WIDTH-1:0]           o_ccu_data;
    logic                            bus_ack;
    logic [WORD_WIDTH-1:0]           bus_rdata;
    logic                            bus_cyc;
    logic                            bus_we;
    logic [ADDR_WIDTH-1:0]           bus_addr;
    logic [WORD_WIDTH-1:0]           bus_wdata;

    // Per-requestor drive values, packed onto the DUT ports below
    logic                  req_valid [ARB_DEPTH];
    logic                  req_we    [ARB_DEPTH];
    logic [LEN_WIDTH-1:0]  req_len   [ARB_DEPTH];
    logic [ADDR_WIDTH-1:0] req_addr  [ARB_DEPTH];
    logic [LINE_WIDTH-1:0] req_data  [ARB_DEPTH];

    // Reference memory keyed by word byte address
    logic [WORD_WIDTH-1:0] ref_mem [logic [ADDR_WIDTH-1:0]];
    int                    done_order [$];
    int                    check_count   = 0;
    int                    error_count   = 0;
    int                    timeout_count = 0;

    // Acknowledged bus beats since the last finished request
    logic [ADDR_WIDTH-1:0] beat_addr  [$];
    logic                  beat_we    [$];
    logic [WORD_WIDTH-1:0] beat_wdata [$];

    always #4 clk = ~clk;

    for (genvar g = 0; g < ARB_DEPTH; g++) begin : g_pack
        assign i_ccu_valid[g]                         = req_valid[g];
        assign i_ccu_we[g]                            = req_we[g];
        assign i_ccu_len[g*LEN_WIDTH +: LEN_WIDTH]    = req_len[g];
        assign i_ccu_addr[g*ADDR_WIDTH +: ADDR_WIDTH] = req_addr[g];
        assign i_ccu_data[g*LINE_WIDTH +: LINE_WIDTH] = req_data[g];
    end

    ccu_top ccu_top_inst (
        .clk (clk), .i_reset (i_reset),
        .i_ccu_valid (i_ccu_valid), .i_ccu_we (i_ccu_we), .i_ccu_len (i_ccu_len),
        .i_ccu_addr (i_ccu_addr), .i_ccu_data (i_ccu_data), .o_ccu_done (o_ccu_done),
        .o_ccu_grant (o_ccu_grant), .o_ccu_data (o_ccu_data),
        .i_bus_ack (bus_ack), .i_bus_rdata (bus_rdata), .o_bus_cyc (bus_cyc),
        .o_bus_we (bus_we), .o_bus_addr (bus_addr), .o_bus_wdata (bus_wdata)
    );

    ccu_mem_model mem_model_inst (
        .clk (clk), .i_reset (i_reset), .i_bus_cyc (bus_cyc), .i_bus_we (bus_we),
        .i_bus_addr (bus_addr), .i_bus_wdata (bus_wdata),
        .o_bus_ack (bus_ack), .o_bus_rdata (bus_rdata)
    );

    // Bus outputs are stable at the falling edge, so beats are logged there
    always @(negedge clk) begin
        if (bus_cyc && bus_ack) begin
            beat_addr.push_back(bus_addr);
            beat_we.push_back(bus_we);
            beat_wdata.push_back(bus_wdata);
        end
    end

    // Words 0..len of the aligned line are written, the rest stay untouched
    function automatic void record_write(input logic [ADDR_WIDTH-1:0] addr,
                                         input int len, input logic [LINE_WIDTH-1:0] line);
        for (int w = 0; w <= len; w++) begin
            ref_mem[(addr & ~32'hf) + 32'(4 * w)] = line[w*WORD_WIDTH +: WORD_WIDTH];
        end
    endfunction

    // Read line has words 0..len from memory and zero above
    function automatic logic [LINE_WIDTH-1:0] expected_line(input logic [ADDR_WIDTH-1:0] addr,
                                                            input int len);
        logic [LINE_WIDTH-1:0] line;
        line = '0;
        for (int w = 0; w <= len; w++) begin
            line[w*WORD_WIDTH +: WORD_WIDTH] = ref_mem[(addr & ~32'hf) + 32'(4 * w)];
        end
        return line;
    endfunction

    // One beat per word at consecutive word addresses of the aligned line
    function automatic void check_beats(input string name, input logic we,
                                        input logic [ADDR_WIDTH-1:0] addr, input int len,
                                        input logic [LINE_WIDTH-1:0] wdata);
        logic [ADDR_WIDTH-1:0] exp_addr;
        logic [WORD_WIDTH-1:0] exp_word;
        if (beat_addr.size() != len + 1) begin
            $display("%s: %0d bus beats seen instead of %0d", name, beat_addr.size(), len + 1);
            error_count++;
        end else begin
            for (int w = 0; w <= len; w++) begin
                exp_addr = (addr & ~32'hf) + 32'(4 * w);
                exp_word = wdata[w*WORD_WIDTH +: WORD_WIDTH];
                if (beat_addr[w] !== exp_addr || beat_we[w] !== we) begin
                    $display("Error: %s beat %0d expected addr %h we %b actual addr %h we %b",
                             name, w, exp_addr, we, beat_addr[w], beat_we[w]);
                    error_count++;
                end else if (we && beat_wdata[w] !== exp_word) begin
                    $display("Error: %s beat %0d expected wdata %h actual %h",
                             name, w, exp_word, beat_wdata[w]);
                    error_count++;
                end
            end
        end
        beat_addr.delete();
        beat_we.delete();
        beat_wdata.delete();
    endfunction

    // Called and returns on a falling edge, holds valid until done
    task automatic request(input int idx, input logic we, input logic [LEN_WIDTH-1:0] len,
                           input logic [ADDR_WIDTH-1:0] addr,
                           input logic [LINE_WIDTH-1:0] wdata, input string name);
        logic [LINE_WIDTH-1:0] exp_line;
        logic [ARB_DEPTH-1:0]  exp_done;
        bit                    saw_grant;
        int                    cycles;
        saw_grant = 1'b0;
        cycles    = 0;
        exp_done  = '0;
        exp_done[idx] = 1'b1;
        req_we[idx]    = we;
        req_len[idx]   = len;
        req_addr[idx]  = addr;
        req_data[idx]  = wdata;
        req_valid[idx] = 1'b1;
        @(negedge clk);
        while (!o_ccu_done[idx] && cycles < TIMEOUT_CYCLES) begin
            if (o_ccu_grant[idx]) begin
                saw_grant = 1'b1;
            end
            cycles++;
            @(negedge clk);
        end
        if (!o_ccu_done[idx]) begin
            $display("Timeout: %s on requestor %0d saw no done in %0d cycles", name, idx, cycles);
            timeout_count++;
        end else begin
            done_order.push_back(idx);
            check_count++;
            if (o_ccu_done !== exp_done) begin
                $display("Error: %s done expected %b actual %b", name, exp_done, o_ccu_done);
                error_count++;
            end
            if (!saw_grant) begin
                $display("%s: requestor %0d got done without a grant first", name, idx);
                error_count++;
            end
            check_beats(name, we, addr, int'(len), wdata);
            if (we) begin
                record_write(addr, int'(len), wdata);
            end else begin
                exp_line = expected_line(addr, int'(len));
                if (o_ccu_data !== exp_line) begin
                    $display("Error: %s expected %h actual %h", name, exp_line, o_ccu_data);
                    error_count++;
                end
            end
        end
        req_valid[idx] = 1'b0;
        @(negedge clk);
    endtask

    task automatic check_idle_after_reset();
        for (int c = 0; c < 10; c++) begin
            check_count++;
            if (o_ccu_grant !== '0 || o_ccu_done !== '0 || bus_cyc !== 1'b0) begin
                $display("Error: idle_after_reset expected grant/done/cyc 000/000/0 actual %b/%b/%b",
                         o_ccu_grant, o_ccu_done, bus_cyc);
                error_count++;
            end
            @(negedge clk);
        end
    endtask

    task automatic full_line_write_read();
        request(1, 1'b1, 2'd3, 32'h0000_0100, 128'h4444_4444_3333_3333_2222_2222_1111_1111,
                "full_write");
        request(0, 1'b0, 2'd3, 32'h0000_010c, '0, "full_read");
    endtask

    task automatic partial_write();
        request(2, 1'b1, 2'd1, 32'h0000_0104, 128'hdead_0004_dead_0003_beef_0002_beef_0001,
                "partial_write");
        request(1, 1'b0, 2'd3, 32'h0000_0100, '0, "partial_read");
    endtask

    task automatic short_read();
        request(0, 1'b0, 2'd0, 32'h0000_0108, '0, "short_read");
    endtask

    task automatic concurrent_requests();
        done_order.delete();
        fork
            request(0, 1'b1, 2'd3, 32'h0000_0300, 128'h0303_0004_0303_0003_0303_0002_0303_0001,
                    "concurrent_r0");
            request(1, 1'b0, 2'd3, 32'h0000_0100, '0, "concurrent_r1");
            request(2, 1'b1, 2'd3, 32'h0000_0400, 128'h0404_0004_0404_0003_0404_0002_0404_0001,
                    "concurrent_r2");
        join
        check_count++;
        if (done_order.size() != 3) begin
            $display("concurrent_order: %0d done pulses seen instead of 3", done_order.size());
            error_count++;
        end else if (done_order[0] != 0 || done_order[1] != 1 || done_order[2] != 2) begin
            $display("Error: concurrent_order expected 0 1 2 actual %0d %0d %0d",
                     done_order[0], done_order[1], done_order[2]);
            error_count++;
        end
        request(2, 1'b0, 2'd3, 32'h0000_0300, '0, "concurrent_readback_r0");
        request(1, 1'b0, 2'd3, 32'h0000_0400, '0, "concurrent_readback_r2");
    endtask

    task automatic random_traffic(input int count);
        logic [ADDR_WIDTH-1:0] addrs [$];
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] line;
        for (int i = 0; i < count; i++) begin
            addr = {16'h0001, 12'($urandom()), 4'h0};
            line = {$urandom(), $urandom(), $urandom(), $urandom()};
            addrs.push_back(addr);
            request(int'($urandom_range(2, 0)), 1'b1, 2'd3, addr, line, "random_write");
        end
        foreach (addrs[i]) begin
            request(int'($urandom_range(2, 0)), 1'b0, LEN_WIDTH'($urandom_range(3, 0)),
                    addrs[i] | 32'($urandom_range(15, 0)), '0, "random_read");
        end
    endtask

    initial begin
        void'($urandom(32'h7b23_5996));
        i_reset = 1'b1;
        for (int r = 0; r < ARB_DEPTH; r++) begin
            req_valid[r] = 1'b0;
            req_we[r]    = 1'b0;
            req_len[r]   = '0;
            req_addr[r]  = '0;
            req_data[r]  = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        check_idle_after_reset();
        full_line_write_read();
        partial_write();
        short_read();
        concurrent_requests();
        random_traffic(12);
        $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
                 check_count, error_count, timeout_count,
                 ccu_top_inst.ccu_props_inst.assert_fail_count);
        if (error_count == 0 && timeout_count == 0 &&
            ccu_top_inst.ccu_props_inst.assert_fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/ccu_props.sv ====
/*
 * Concurrent checks on the CCU top level, bound into every ccu_top.
 * Covers the grant and done encodings and the bus hold rule.
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_props import ccu_pkg::*; (
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic [ARB_DEPTH-1:0] i_grant,
    input  logic [ARB_DEPTH-1:0] i_done,
    input  logic                 i_bus_cyc,
    input  logic                 i_bus_ack
);

    int assert_fail_count = 0;

    grant_onehot: assert property (@(posedge clk) disable iff (i_reset) $onehot0(i_grant))
        else begin
            assert_fail_count++;
            $error("More than one grant bit high: %b", i_grant);
        end

    done_onehot: assert property (@(posedge clk) disable iff (i_reset) $onehot0(i_done))
        else begin
            assert_fail_count++;
            $error("More than one done bit high: %b", i_done);
        end

    // A beat may not be abandoned before the memory acknowledges it
    cyc_until_ack: assert property (@(posedge clk) disable iff (i_reset)
        (i_bus_cyc && !i_bus_ack) |=> i_bus_cyc)
        else begin
            assert_fail_count++;
            $error("Bus cyc dropped before ack");
        end

endmodule

bind ccu_top ccu_props ccu_props_inst (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_grant   (o_ccu_grant),
    .i_done    (o_ccu_done),
    .i_bus_cyc (o_bus_cyc),
    .i_bus_ack (i_bus_ack)
);

`default_nettype wire

// ==== testbench/ccu_mem_model.sv ====
/*
 * Behavioral word memory on the CCU memory bus.
 * Each beat is acknowledged after a random number of wait cycles, and
 * words never written read back as a hash of their address.
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_mem_model import ccu_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_bus_cyc,
    input  logic                  i_bus_we,
    input  logic [ADDR_WIDTH-1:0] i_bus_addr,
    input  logic [WORD_WIDTH-1:0] i_bus_wdata,
    output logic                  o_bus_ack,
    output logic [WORD_WIDTH-1:0] o_bus_rdata
);

    logic [WORD_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
    logic                  busy;
    int                    wait_cnt;

    // Multiplicative hash, so every address bit changes the fill word
    function automatic logic [WORD_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
        return addr * 32'h9e37_79b1 + 32'h3c5a_96e1;
    endfunction

    // A beat starts when cyc is seen, waits 0 to 3 extra cycles, then acks once
    always @(posedge clk) begin
        if (i_reset) begin
            o_bus_ack   <= 1'b0;
            o_bus_rdata <= '0;
            busy        <= 1'b0;
            wait_cnt    <= 0;
        end else begin
            o_bus_ack <= 1'b0;
            if (i_bus_cyc && !o_bus_ack) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= int'($urandom_range(3, 0));
                end else if (wait_cnt == 0) begin
                    busy      <= 1'b0;
                    o_bus_ack <= 1'b1;
                    if (i_bus_we) begin
                        mem[i_bus_addr] = i_bus_wdata;
                    end else if (mem.exists(i_bus_addr)) begin
                        o_bus_rdata <= mem[i_bus_addr];
                    end else begin
                        o_bus_rdata <= fill_word(i_bus_addr);
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ccu_top.sv ====
/*
 * Top level of the core communications unit.
 * Requestors connect on the packed ccu ports, the memory on the bus ports.
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_top import ccu_pkg::*; (
    input  logic                            clk,
    input  logic                            i_reset,

    // Requestor ports
    input  logic [ARB_DEPTH-1:0]            i_ccu_valid,
    input  logic [ARB_DEPTH-1:0]            i_ccu_we,
    input  logic [ARB_DEPTH*LEN_WIDTH-1:0]  i_ccu_len,
    input  logic [ARB_DEPTH*ADDR_WIDTH-1:0] i_ccu_addr,
    input  logic [ARB_DEPTH*LINE_WIDTH-1:0] i_ccu_data,
    output logic [ARB_DEPTH-1:0]            o_ccu_done,
    output logic [ARB_DEPTH-1:0]            o_ccu_grant,
    output logic [LINE_WIDTH-1:0]           o_ccu_data,

    // Memory bus ports
    input  logic                            i_bus_ack,
    input  logic [WORD_WIDTH-1:0]           i_bus_rdata,
    output logic                            o_bus_cyc,
    output logic                            o_bus_we,
    output logic [ADDR_WIDTH-1:0]           o_bus_addr,
    output logic [WORD_WIDTH-1:0]           o_bus_wdata
);

    // Arbiter to BIU command and the BIU's reply
    logic                   biu_en;
    biu_func_t              biu_func;
    logic [LEN_WIDTH-1:0]   biu_len;
    logic [ADDR_WIDTH-1:0]  biu_addr;
    logic [LINE_WIDTH-1:0]  biu_wline;
    logic                   biu_done;
    logic [LINE_WIDTH-1:0]  biu_rline;

    ccu_arb ccu_arb_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_ccu_valid (i_ccu_valid),
        .i_ccu_we    (i_ccu_we),
        .i_ccu_len   (i_ccu_len),
        .i_ccu_addr  (i_ccu_addr),
        .i_ccu_data  (i_ccu_data),
        .o_ccu_done  (o_ccu_done),
        .o_ccu_grant (o_ccu_grant),
        .o_ccu_data  (o_ccu_data),
        .i_biu_done  (biu_done),
        .i_biu_data  (biu_rline),
        .o_biu_en    (biu_en),
        .o_biu_func  (biu_func),
        .o_biu_len   (biu_len),
        .o_biu_addr  (biu_addr),
        .o_biu_data  (biu_wline)
    );

    ccu_biu ccu_biu_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_biu_en    (biu_en),
        .i_biu_func  (biu_func),
        .i_biu_len   (biu_len),
        .i_biu_addr  (biu_addr),
        .i_biu_data  (biu_wline),
        .o_biu_done  (biu_done),
        .o_biu_data  (biu_rline),
        .i_bus_ack   (i_bus_ack),
        .i_bus_rdata (i_bus_rdata),
        .o_bus_cyc   (o_bus_cyc),
        .o_bus_we    (o_bus_we),
        .o_bus_addr  (o_bus_addr),
        .o_bus_wdata (o_bus_wdata)
    );

endmodule

`default_nettype wire

// ==== verilog/ccu_biu.sv ====
/*
 * Bus interface unit between the arbiter and the word-wide memory bus.
 * One line command is split into len+1 single-word beats at consecutive
 * word addresses. Read words are gathered into a line register and
 * handed back with a one-cycle done pulse.
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_biu import ccu_pkg::*; (
    input  logic                    clk,
    input  logic                    i_reset,

    // Command from the arbiter
    input  logic                    i_biu_en,
    input  biu_func_t               i_biu_func,
    input  logic [LEN_WIDTH-1:0]    i_biu_len,
    input  logic [ADDR_WIDTH-1:0]   i_biu_addr,
    input  logic [LINE_WIDTH-1:0]   i_biu_data,
    output logic                    o_biu_done,
    output logic [LINE_WIDTH-1:0]   o_biu_data,

    // Memory bus
    input  logic                    i_bus_ack,
    input  logic [WORD_WIDTH-1:0]   i_bus_rdata,
    output logic                    o_bus_cyc,
    output logic                    o_bus_we,
    output logic [ADDR_WIDTH-1:0]   o_bus_addr,
    output logic [WORD_WIDTH-1:0]   o_bus_wdata
);

    biu_state_t                 state_r;
    biu_state_t                 state_next;
    logic [BEAT_WIDTH-1:0]      beat_r;
    logic                       beat_last;
    logic                       start;
    logic                       beat_done;

    // Latched command
    biu_func_t                  func_r;
    logic [LEN_WIDTH-1:0]       len_r;
    logic [ADDR_WIDTH-1:0]      addr_r;
    logic [LINE_WIDTH-1:0]      wline_r;
    logic [LINE_WIDTH-1:0]      rline_r;

    assign start     = (state_r == BIU_IDLE) && i_biu_en;
    assign beat_done = o_bus_cyc && i_bus_ack;
    assign beat_last = (beat_r == len_r);

    always_comb begin
        state_next = state_r;
        case (state_r)
            BIU_IDLE: begin
                if (i_biu_en) begin
                    state_next = BIU_BEAT;
                end
            end
            BIU_BEAT: begin
                if (beat_done && beat_last) begin
                    state_next = BIU_DONE;
                end
            end
            BIU_DONE: state_next = BIU_IDLE;
            default:  state_next = BIU_IDLE;
        endcase
    end

    // The beat counter restarts with each command and steps on every ack
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= BIU_IDLE;
            beat_r  <= '0;
        end else begin
            state_r <= state_next;
            if (start) begin
                beat_r <= '0;
            end else if (beat_done) begin
                beat_r <= beat_r + 1'b1;
            end
        end
    end

    // Line address has its low four bits forced to zero
    always_ff @(posedge clk) begin
        if (start) begin
            func_r  <= i_biu_func;
            len_r   <= i_biu_len;
            addr_r  <= i_biu_addr & ~ADDR_WIDTH'(LINE_WORDS * (WORD_WIDTH / 8) - 1);
            wline_r <= i_biu_data;
        end
    end

    // Cleared at start so words past len come back as zero
    always_ff @(posedge clk) begin
        if (start) begin
            rline_r <= '0;
        end else if (beat_done && func_r == BIU_FUNC_READ) begin
            rline_r[beat_r*WORD_WIDTH +: WORD_WIDTH] <= i_bus_rdata;
        end
    end

    // Bus signals come straight from registers and hold while waiting for ack
    assign o_bus_cyc   = (state_r == BIU_BEAT);
    assign o_bus_we    = o_bus_cyc && (func_r == BIU_FUNC_WRITE);
    assign o_bus_addr  = addr_r + ADDR_WIDTH'({beat_r, 2'b00});
    assign o_bus_wdata = wline_r[beat_r*WORD_WIDTH +: WORD_WIDTH];

    assign o_biu_done  = (state_r == BIU_DONE);
    assign o_biu_data  = rline_r;

endmodule

`default_nettype wire

// ==== verilog/ccu_arb.sv ====
/*
 * Fixed priority arbiter in front of the bus interface unit.
 * Requestor 0 wins over 1, and 1 over 2. The winner gets a one-cycle grant,
 * its command is registered toward the BIU, and a one-cycle done pulse plus
 * the returned line go back to that requestor alone.
 */

`timescale 1ns/1ps
`default_nettype none

module ccu_arb import ccu_pkg::*; (
    input  logic                            clk,
    input  logic                            i_reset,

    // Requestor side, one slice per requestor
    input  logic [ARB_DEPTH-1:0]            i_ccu_valid,
    input  logic [ARB_DEPTH-1:0]            i_ccu_we,
    input  logic [ARB_DEPTH*LEN_WIDTH-1:0]  i_ccu_len,
    input  logic [ARB_DEPTH*ADDR_WIDTH-1:0] i_ccu_addr,
    input  logic [ARB_DEPTH*LINE_WIDTH-1:0] i_ccu_data,
    output logic [ARB_DEPTH-1:0]            o_ccu_done,
    output logic [ARB_DEPTH-1:0]            o_ccu_grant,
    output logic [LINE_WIDTH-1:0]           o_ccu_data,

    // BIU side
    input  logic                            i_biu_done,
    input  logic [LINE_WIDTH-1:0]           i_biu_data,
    output logic                            o_biu_en,
    output biu_func_t                       o_biu_func,
    output logic [LEN_WIDTH-1:0]            o_biu_len,
    output logic [ADDR_WIDTH-1:0]           o_biu_addr,
    output logic [LINE_WIDTH-1:0]           o_biu_data
);

    arb_state_t                 state_r;
    arb_state_t                 state_next;
    logic [ARB_DEPTH-1:0]       arb_select;
    logic [ARB_IDX_WIDTH-1:0]   arb_idx;
    logic [ARB_IDX_WIDTH-1:0]   idx_r;
    logic [ARB_DEPTH-1:0]       arb_grant;
    logic [ARB_DEPTH-1:0]       arb_done;
    logic                       biu_en;
    biu_func_t                  sel_func;

    // Isolate the lowest set valid bit, so bit 0 has the highest priority
    assign arb_select = i_ccu_valid & (~i_ccu_valid + 1'b1);

    // One-hot pick to binary index
    always_comb begin
        arb_idx = '0;
        for (int i = 0; i < ARB_DEPTH; i++) begin
            if (arb_select[i]) begin
                arb_idx = ARB_IDX_WIDTH'(i);
            end
        end
    end

    // The index is frozen once the FSM leaves idle and steers all muxes below
    always_ff @(posedge clk) begin
        if (state_r == ARB_IDLE) begin
            idx_r <= arb_idx;
        end
    end

    // Idle waits for any request, busy waits for the BIU, done lasts one cycle
    always_comb begin
        state_next = state_r;
        case (state_r)
            ARB_IDLE: begin
                if (arb_select != '0) begin
                    state_next = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                if (i_biu_done) begin
                    state_next = ARB_DONE;
                end
            end
            ARB_DONE: state_next = ARB_IDLE;
            default:  state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= ARB_IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    // Grant goes out while idle, done and the BIU enable only while busy
    always_comb begin
        arb_grant = '0;
        arb_done  = '0;
        biu_en    = 1'b0;
        case (state_r)
            ARB_IDLE: begin
                arb_grant = arb_select;
            end
            ARB_BUSY: begin
                arb_done[idx_r] = i_biu_done;
                biu_en          = i_ccu_valid[idx_r] && !i_biu_done;
            end
            default: begin
                arb_grant = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ccu_grant <= '0;
            o_ccu_done  <= '0;
            o_biu_en    <= 1'b0;
        end else begin
            o_ccu_grant <= arb_grant;
            o_ccu_done  <= arb_done;
            o_biu_en    <= biu_en;
        end
    end

    // Write flag of the selected requestor becomes the BIU function code
    assign sel_func = i_ccu_we[idx_r] ? BIU_FUNC_WRITE : BIU_FUNC_READ;

    // Command fields follow the selected slice every cycle
    always_ff @(posedge clk) begin
        o_biu_func <= sel_func;
        o_biu_len  <= i_ccu_len[idx_r*LEN_WIDTH +: LEN_WIDTH];
        o_biu_addr <= i_ccu_addr[idx_r*ADDR_WIDTH +: ADDR_WIDTH];
        o_biu_data <= i_ccu_data[idx_r*LINE_WIDTH +: LINE_WIDTH];
    end

    // Line is captured alongside the done pulse and held until the next one
    always_ff @(posedge clk) begin
        if (i_biu_done) begin
            o_ccu_data <= i_biu_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ccu_pkg.sv ====
/*
 * Shared sizes and encodings for the core communications unit.
 * Every RTL module and the testbench import this package by wildcard.
 * Line, word and requestor counts are fixed here and nowhere else.
 */

`default_nettype none

package ccu_pkg;

    // Byte address and bus word sizes
    localparam int ADDR_WIDTH    = 32;
    localparam int WORD_WIDTH    = 32;

    // A line is four bus words
    localparam int LINE_WORDS    = 4;
    localparam int LINE_WIDTH    = WORD_WIDTH * LINE_WORDS;

    // Number of requestors sharing the bus and the width of their index
    localparam int ARB_DEPTH     = 3;
    localparam int ARB_IDX_WIDTH = 2;

    // Length field holds the word count minus one
    localparam int LEN_WIDTH     = 2;
    localparam int BEAT_WIDTH    = 2;

    // Function code handed from the arbiter to the BIU
    typedef enum logic {
        BIU_FUNC_READ  = 1'b0,
        BIU_FUNC_WRITE = 1'b1
    } biu_func_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_t;

    // BIU_BEAT covers every beat of a command, cyc is high throughout
    typedef enum logic [1:0] {
        BIU_IDLE = 2'b00,
        BIU_BEAT = 2'b01,
        BIU_DONE = 2'b10
    } biu_state_t;

endpackage

`default_nettype wire
